//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int COLOR_W = 4;
    localparam int WORD_W = 16;

    // one byte from the download link, addr counts from download start
    typedef struct packed {
        logic        wr;
        logic [21:0] addr;
        logic [7:0]  data;
    } ioctl_bus_t;

    // raster position travels with its syncs
    typedef struct packed {
        logic       hs;
        logic       vs;
        logic       de;
        logic [9:0] x;
        logic [9:0] y;
    } video_sync_t;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

    typedef enum logic [1:0] {
        st_idle, st_load, st_flush, st_play
    } core_state_t;

endpackage

`default_nettype wire

//--- hw/spi_download.sv
`timescale 1ns/10ps
`default_nettype none

module spi_download import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       spi_sck,
    input  logic       spi_ss2,
    input  logic       spi_di,
    output logic       downloading,
    output ioctl_bus_t ioctl
);

    logic [1:0]  sck_sync;
    logic [1:0]  ss_sync;
    logic [1:0]  di_sync;
    logic        sck_last;
    logic        sck_rise;
    logic [2:0]  bit_cnt;
    logic [6:0]  shift;
    logic [21:0] byte_cnt;

    assign sck_rise    = sck_sync[1] & ~sck_last;
    assign downloading = ~ss_sync[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_sync <= 2'b00;
            ss_sync  <= 2'b11;
            di_sync  <= 2'b00;
            sck_last <= 1'b0;
            bit_cnt  <= 3'd0;
            byte_cnt <= 22'd0;
            ioctl    <= '0;
        end else begin
            sck_sync <= {sck_sync[0], spi_sck};
            ss_sync  <= {ss_sync[0], spi_ss2};
            // data follows the same delay so it lines up with the clock edge
            di_sync  <= {di_sync[0], spi_di};
            sck_last <= sck_sync[1];
            ioctl.wr <= 1'b0;
            if (ss_sync[1]) begin
                // deselected, next download starts again at byte 0
                bit_cnt  <= 3'd0;
                byte_cnt <= 22'd0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                shift   <= {shift[5:0], di_sync[1]};
                if (bit_cnt == 3'd7) begin
                    ioctl.wr   <= 1'b1;
                    ioctl.addr <= byte_cnt;
                    ioctl.data <= {shift, di_sync[1]};
                    byte_cnt   <= byte_cnt + 22'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rom_store.sv
`timescale 1ns/10ps
`default_nettype none

module rom_store import core_pkg::*; #(
    parameter int ROM_AW = 6
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  ioctl_bus_t        ioctl,
    input  logic [ROM_AW-1:0] rd_addr,
    output logic              flush_done,
    output logic [WORD_W-1:0] rd_data
);

    logic [WORD_W-1:0] mem [2**ROM_AW];

    logic [7:0]        pend_byte;
    logic [ROM_AW-1:0] pend_addr;
    logic              pend_valid;
    logic              wr_en;
    logic [ROM_AW-1:0] wr_addr;
    logic [WORD_W-1:0] wr_word;

    // byte pairs become one word, high byte first
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            wr_en      <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            wr_en      <= 1'b0;
            flush_done <= flush;
            if (ioctl.wr) begin
                if (!ioctl.addr[0]) begin
                    pend_byte  <= ioctl.data;
                    pend_addr  <= ioctl.addr[ROM_AW:1];
                    pend_valid <= 1'b1;
                end else begin
                    wr_en      <= 1'b1;
                    wr_addr    <= ioctl.addr[ROM_AW:1];
                    wr_word    <= {pend_byte, ioctl.data};
                    pend_valid <= 1'b0;
                end
            end else if (flush && pend_valid) begin
                // odd length image, low half is padded with zero
                wr_en      <= 1'b1;
                wr_addr    <= pend_addr;
                wr_word    <= {pend_byte, 8'h00};
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing import core_pkg::*; #(
    parameter int H_ACTIVE = 8,
    parameter int H_TOTAL  = 12,
    parameter int V_ACTIVE = 4,
    parameter int V_TOTAL  = 6
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        play,
    output logic        pxl_cen,
    output video_sync_t sync
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;

    // counters sit at zero until the core starts playing
    always_ff @(posedge clk) begin
        if (reset || !play) begin
            pxl_cen <= 1'b0;
            h_cnt   <= 10'd0;
            v_cnt   <= 10'd0;
        end else begin
            // half rate pixel enable
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                if (h_cnt == 10'(H_TOTAL - 1)) begin
                    h_cnt <= 10'd0;
                    if (v_cnt == 10'(V_TOTAL - 1)) begin
                        v_cnt <= 10'd0;
                    end else begin
                        v_cnt <= v_cnt + 10'd1;
                    end
                end else begin
                    h_cnt <= h_cnt + 10'd1;
                end
            end
        end
    end

    // sync decode, all quiet while not playing
    always_comb begin
        sync.x  = h_cnt;
        sync.y  = v_cnt;
        sync.de = play && (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));
        sync.hs = play && (h_cnt >= 10'(H_TOTAL - 2));
        sync.vs = play && (v_cnt == 10'(V_TOTAL - 1));
    end

endmodule

`default_nettype wire

//--- hw/pixel_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch import core_pkg::*; #(
    parameter int H_ACTIVE = 8,
    parameter int ROM_AW   = 6
) (
    input  logic              clk,
    input  logic              reset,
    input  video_sync_t       sync,
    input  logic [WORD_W-1:0] rd_data,
    output logic [ROM_AW-1:0] rd_addr,
    output video_sync_t       sync_out,
    output rgb_t              rgb
);

    logic [19:0] lin_addr;

    // linear pixel index, wraps around the word memory
    assign lin_addr = 20'(sync.y) * 20'(H_ACTIVE) + 20'(sync.x);
    assign rd_addr  = lin_addr[ROM_AW-1:0];

    // memory read takes one clk, so the syncs are held back by one too
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_out <= '0;
        end else begin
            sync_out <= sync;
        end
    end

    // 12 bit colour from the low bits of the word, black in blanking
    always_comb begin
        if (sync_out.de) begin
            rgb.r = rd_data[2*COLOR_W +: COLOR_W];
            rgb.g = rd_data[COLOR_W +: COLOR_W];
            rgb.b = rd_data[0 +: COLOR_W];
        end else begin
            rgb = '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/core_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module core_ctrl import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    input  logic        flush_done,
    input  logic        vs_out,
    output logic        flush,
    output logic        play,
    output logic        led,
    output logic [31:0] frame_cnt
);

    core_state_t state;
    logic        dl_last;
    logic        vs_last;
    logic        dl_rise;
    logic        dl_fall;

    assign dl_rise = downloading & ~dl_last;
    assign dl_fall = ~downloading & dl_last;
    assign play    = (state == st_play);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            dl_last   <= 1'b0;
            vs_last   <= 1'b0;
            flush     <= 1'b0;
            led       <= 1'b1;
            frame_cnt <= 32'd0;
        end else begin
            dl_last <= downloading;
            vs_last <= vs_out;
            flush   <= 1'b0;
            // led is low from load until the image is complete
            led     <= (state == st_idle) || (state == st_play);
            case (state)
                st_idle: begin
                    if (dl_rise) state <= st_load;
                end
                st_load: begin
                    if (dl_fall) begin
                        state <= st_flush;
                        flush <= 1'b1;
                    end
                end
                st_flush: begin
                    if (flush_done) state <= st_play;
                end
                st_play: begin
                    if (dl_rise) begin
                        state <= st_load;
                    end else if (vs_out && !vs_last) begin
                        frame_cnt <= frame_cnt + 32'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/game_top.sv
`timescale 1ns/10ps
`default_nettype none

module game_top import core_pkg::*; #(
    parameter int H_ACTIVE = 8,
    parameter int H_TOTAL  = 12,
    parameter int V_ACTIVE = 4,
    parameter int V_TOTAL  = 6,
    parameter int ROM_AW   = 6
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        spi_sck,
    input  logic        spi_ss2,
    input  logic        spi_di,
    output logic        led,
    output logic        hs,
    output logic        vs,
    output logic        pxl_cen,
    output rgb_t        rgb,
    output logic [31:0] frame_cnt
);

    ioctl_bus_t        ioctl;
    video_sync_t       sync;
    video_sync_t       sync_out;
    logic              downloading;
    logic              flush;
    logic              flush_done;
    logic              play;
    logic [ROM_AW-1:0] rd_addr;
    logic [WORD_W-1:0] rd_data;

    // syncs leave aligned with the colour
    assign hs = sync_out.hs;
    assign vs = sync_out.vs;

    spi_download spi_download_inst (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .downloading ( downloading ),
        .ioctl       ( ioctl       )
    );

    rom_store #(.ROM_AW(ROM_AW)) rom_store_inst (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .flush      ( flush      ),
        .ioctl      ( ioctl      ),
        .rd_addr    ( rd_addr    ),
        .flush_done ( flush_done ),
        .rd_data    ( rd_data    )
    );

    core_ctrl core_ctrl_inst (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .flush_done  ( flush_done  ),
        .vs_out      ( sync_out.vs ),
        .flush       ( flush       ),
        .play        ( play        ),
        .led         ( led         ),
        .frame_cnt   ( frame_cnt   )
    );

    video_timing #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) video_timing_inst (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .play    ( play    ),
        .pxl_cen ( pxl_cen ),
        .sync    ( sync    )
    );

    pixel_fetch #(
        .H_ACTIVE ( H_ACTIVE ),
        .ROM_AW   ( ROM_AW   )
    ) pixel_fetch_inst (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .sync     ( sync     ),
        .rd_data  ( rd_data  ),
        .rd_addr  ( rd_addr  ),
        .sync_out ( sync_out ),
        .rgb      ( rgb      )
    );

endmodule

`default_nettype wire

//--- testbench/game_tb.sv
`timescale 1ns/10ps
`default_nettype none

module game_tb import core_pkg::*; ();

    localparam int H_ACTIVE = 8;
    localparam int H_TOTAL  = 12;
    localparam int V_ACTIVE = 4;
    localparam int V_TOTAL  = 6;
    localparam int ROM_AW   = 6;
    // each serial bit holds both sck levels for 3 clk
    localparam int BYTE_CLKS  = 8 * 6;
    localparam int DL_BYTES   = 64 + 7 + 64;
    localparam int FRAME_CLKS = 2 * H_TOTAL * V_TOTAL;
    localparam int CLK_LIMIT  = 4 * (DL_BYTES * BYTE_CLKS + 10 * FRAME_CLKS);

    logic        clk;
    logic        reset;
    logic        spi_sck;
    logic        spi_ss2;
    logic        spi_di;
    logic        led;
    logic        hs;
    logic        vs;
    logic        pxl_cen;
    rgb_t        rgb;
    logic [31:0] frame_cnt;

    logic [31:0] lfsr;
    logic [7:0]  img [$];
    logic [15:0] model_mem [2**ROM_AW];
    logic [11:0] pix [2**ROM_AW];
    int          err_cnt;
    int          check_cnt;
    int          tests_run;
    int          cycle_cnt  = 0;
    int          idle_clks  = 100;
    int          pxl_pulses = 0;
    int          vs_rises   = 0;
    int          mon_x      = 0;
    int          mon_y      = 0;
    logic        hs_prev    = 1'b0;
    logic        vs_prev    = 1'b0;

    game_top #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .ROM_AW   ( ROM_AW   )
    ) game_top_inst (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .spi_sck   ( spi_sck   ),
        .spi_ss2   ( spi_ss2   ),
        .spi_di    ( spi_di    ),
        .led       ( led       ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .pxl_cen   ( pxl_cen   ),
        .rgb       ( rgb       ),
        .frame_cnt ( frame_cnt )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CLK_LIMIT) begin
            $display("run timed out after %0d clock cycles", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    // pixel monitor, position rebuilt from the sync edges
    always @(negedge clk) begin
        if (!pxl_cen) begin
            idle_clks = idle_clks + 1;
        end else begin
            pxl_pulses = pxl_pulses + 1;
            if (idle_clks > 2) begin
                // raster starts over at the origin after a pause
                mon_x = 0;
                mon_y = 0;
            end else if (hs_prev && !hs) begin
                mon_x = 0;
                mon_y = (vs_prev && !vs) ? 0 : mon_y + 1;
            end else begin
                mon_x = mon_x + 1;
            end
            if (vs && !vs_prev) begin
                vs_rises = vs_rises + 1;
            end
            if (mon_x < H_ACTIVE && mon_y < V_ACTIVE) begin
                pix[6'(mon_y * H_ACTIVE + mon_x)] = rgb;
            end
            hs_prev   = hs;
            vs_prev   = vs;
            idle_clks = 0;
        end
    end

    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    task automatic check_value(input string msg, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        $display("%s: done with %0d errors", name, err_cnt - err_before);
    endtask

    task automatic make_image(input int n_bytes);
        logic [7:0] b;
        img.delete();
        for (int i = 0; i < n_bytes; i++) begin
            b = '0;
            for (int k = 0; k < 8; k++) begin
                b = {b[6:0], lfsr_step()};
            end
            img.push_back(b);
        end
        // big-endian words, a lone last byte pairs with zero
        for (int i = 0; i < n_bytes; i += 2) begin
            model_mem[6'(i / 2)] = {img[i], (i + 1 < n_bytes) ? img[i + 1] : 8'h00};
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [7:0] sh;
        sh = b;
        repeat (8) begin
            @(posedge clk);
            spi_sck <= 1'b0;
            spi_di  <= sh[7];
            sh = sh << 1;
            repeat (3) @(posedge clk);
            spi_sck <= 1'b1;
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic download();
        @(posedge clk);
        spi_ss2 <= 1'b0;
        repeat (6) @(posedge clk);
        foreach (img[i]) begin
            send_byte(img[i]);
            @(negedge clk);
            check_value("led low while loading", 32'(led), 32'd0);
        end
        @(posedge clk);
        spi_sck <= 1'b0;
        repeat (4) @(posedge clk);
        spi_ss2 <= 1'b1;
    endtask

    task automatic wait_led_high();
        int n;
        n = 0;
        @(negedge clk);
        while (!led && n < 10) begin
            @(negedge clk);
            n++;
        end
        check_value("led high within 10 cycles of spi_ss2 rise", 32'(led), 32'd1);
    endtask

    task automatic wait_frame();
        int target;
        target = vs_rises + 1;
        while (vs_rises < target) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic compare_frame();
        for (int i = 0; i < H_ACTIVE * V_ACTIVE; i++) begin
            check_value($sformatf("colour of pixel %0d", i),
                        32'(pix[6'(i)]), 32'(model_mem[6'(i)][11:0]));
        end
    endtask

    task automatic test_reset_state();
        int e0;
        int sync_clks;
        e0 = err_cnt;
        sync_clks = 0;
        check_value("led after reset", 32'(led), 32'd1);
        check_value("frame_cnt after reset", frame_cnt, 32'd0);
        repeat (200) begin
            @(negedge clk);
            if (hs || vs) begin
                sync_clks++;
            end
        end
        check_value("pixel enables before download", 32'(pxl_pulses), 32'd0);
        check_value("sync pulses before download", 32'(sync_clks), 32'd0);
        finish_test("reset_state", e0);
    endtask

    task automatic test_download_led();
        int e0;
        e0 = err_cnt;
        make_image(64);
        download();
        wait_led_high();
        finish_test("download_led", e0);
    endtask

    task automatic test_image_pixels();
        int e0;
        e0 = err_cnt;
        wait_frame();
        compare_frame();
        finish_test("image_pixels", e0);
    endtask

    task automatic test_frame_count();
        int          e0;
        logic [31:0] f0;
        e0 = err_cnt;
        wait_frame();
        f0 = frame_cnt;
        // one count per observed vs pulse
        for (int k = 1; k <= 3; k++) begin
            wait_frame();
            check_value("frame_cnt step per vs pulse", frame_cnt - f0, 32'(k));
        end
        finish_test("frame_count", e0);
    endtask

    task automatic test_odd_flush();
        int e0;
        e0 = err_cnt;
        make_image(7);
        download();
        wait_led_high();
        wait_frame();
        check_value("low byte of last word", 32'(pix[6'd3][7:0]), 32'd0);
        compare_frame();
        finish_test("odd_flush", e0);
    endtask

    task automatic test_reload_play();
        int e0;
        e0 = err_cnt;
        make_image(64);
        download();
        wait_led_high();
        wait_frame();
        compare_frame();
        finish_test("reload_play", e0);
    endtask

    initial begin
        reset     = 1'b1;
        spi_sck   = 1'b0;
        spi_ss2   = 1'b1;
        spi_di    = 1'b0;
        lfsr      = 32'h8b36_d1f9;
        err_cnt   = 0;
        check_cnt = 0;
        tests_run = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset_state();
        test_download_led();
        test_image_pixels();
        test_frame_count();
        test_odd_flush();
        test_reload_play();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/core_pkg.sv
hw/spi_download.sv
hw/rom_store.sv
hw/video_timing.sv
hw/pixel_fetch.sv
hw/core_ctrl.sv
hw/game_top.sv
testbench/game_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the game core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module game_tb -f vlog.f -o game_tb_sim

./obj_dir/game_tb_sim > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
